/* stream_types_pkg.sv */
package stream_types_pkg;

	// channel 0 payload
	typedef struct packed {
		logic [3:0]  tag;	// sensor channel tag
		logic [11:0] value;	// raw sample
	} sample_t;

	// channel 1 payload
	typedef struct packed {
		logic [3:0] opcode;
		logic [3:0] target;
		logic [7:0] arg;
	} ctrl_word_t;

	// raw word on the merged output bus
	typedef logic [15:0] bus_word_t;

	// which producer a bus word came from
	typedef enum logic {
		SRC_SAMPLE = 1'b0,
		SRC_CTRL   = 1'b1
	} src_id_t;

endpackage

/* gray_pkg.sv */
package gray_pkg;

	// pointers are handled zero-extended to this width, callers cut back to PTR+1
	localparam int GRAY_W = 16;

	typedef logic [GRAY_W-1:0] ptr_word_t;

	function automatic ptr_word_t bin2gray(input ptr_word_t bin);
		return bin ^ (bin >> 1);
	endfunction

	// prefix xor from the msb down
	function automatic ptr_word_t gray2bin(input ptr_word_t gray);
		ptr_word_t bin;
		bin[GRAY_W-1] = gray[GRAY_W-1];
		for (int i = GRAY_W - 2; i >= 0; i--) begin
			bin[i] = bin[i+1] ^ gray[i];
		end
		return bin;
	endfunction

endpackage

/* dpram.sv */
`timescale 1ns/1ps

module dpram #(
	parameter int PTR = 4,
	parameter type payload_t = logic [15:0]
) (
	input  logic           wrclk,
	input  logic           wr_en,
	input  logic [PTR-1:0] wr_addr,
	input  payload_t       wr_data,

	input  logic           rdclk,
	input  logic           rd_rst_n,
	input  logic           rd_en,
	input  logic [PTR-1:0] rd_addr,
	output payload_t       rd_data
);

	localparam int DEPTH = 1 << PTR;

	payload_t mem [DEPTH];

	always_ff @(posedge wrclk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// registered read port, holds the last word between reads
	always_ff @(posedge rdclk or negedge rd_rst_n) begin
		if (!rd_rst_n) begin
			rd_data <= '0;
		end else if (rd_en) begin
			rd_data <= mem[rd_addr];
		end
	end

endmodule

/* ptr_sync.sv */
`timescale 1ns/1ps

module ptr_sync import gray_pkg::*; #(
	parameter int PTR = 4
) (
	input  logic         clk,
	input  logic         rst_n,
	input  logic [PTR:0] gray_in,	// from the other clock domain
	output logic [PTR:0] bin_out
);

	localparam int PW = PTR + 1;

	logic [PTR:0] sync1;
	logic [PTR:0] sync2;

	// only one bit of gray_in changes per step, so two flops are enough
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sync1 <= '0;
			sync2 <= '0;
		end else begin
			sync1 <= gray_in;
			sync2 <= sync1;
		end
	end

	always_comb begin
		bin_out = PW'(gray2bin(ptr_word_t'(sync2)));	// local binary view
	end

endmodule

/* async_fifo.sv */
`timescale 1ns/1ps

module async_fifo import gray_pkg::*; #(
	parameter int PTR = 4,
	parameter type payload_t = logic [15:0]
) (
	input  logic     wrclk,
	input  logic     wr_rst_n,
	input  logic     wr_en,
	input  payload_t wr_data,
	output logic     wr_full,

	input  logic     rdclk,
	input  logic     rd_rst_n,
	input  logic     rd_en,
	output payload_t rd_data,
	output logic     rd_empty
);

	localparam int PW = PTR + 1;

	logic [PTR:0] wr_bin;		// write pointer with wrap bit
	logic [PTR:0] wr_gray;
	logic [PTR:0] rd_bin_wr;	// read pointer seen in write domain

	logic [PTR:0] rd_bin;
	logic [PTR:0] rd_gray;
	logic [PTR:0] wr_bin_rd;	// write pointer seen in read domain

	logic wr_push;
	logic rd_pop;

	assign wr_push = wr_en && !wr_full;
	assign rd_pop  = rd_en && !rd_empty;

	always_ff @(posedge wrclk or negedge wr_rst_n) begin
		if (!wr_rst_n) begin
			wr_bin  <= '0;
			wr_gray <= '0;
		end else begin
			if (wr_push) begin
				wr_bin <= wr_bin + 1'b1;
			end
			wr_gray <= PW'(bin2gray(ptr_word_t'(wr_bin)));	// lags wr_bin by one cycle
		end
	end

	always_ff @(posedge rdclk or negedge rd_rst_n) begin
		if (!rd_rst_n) begin
			rd_bin  <= '0;
			rd_gray <= '0;
		end else begin
			if (rd_pop) begin
				rd_bin <= rd_bin + 1'b1;
			end
			rd_gray <= PW'(bin2gray(ptr_word_t'(rd_bin)));
		end
	end

	ptr_sync #(.PTR(PTR)) u_sync_rd2wr (
		.clk     (wrclk),
		.rst_n   (wr_rst_n),
		.gray_in (rd_gray),
		.bin_out (rd_bin_wr)
	);

	ptr_sync #(.PTR(PTR)) u_sync_wr2rd (
		.clk     (rdclk),
		.rst_n   (rd_rst_n),
		.gray_in (wr_gray),
		.bin_out (wr_bin_rd)
	);

	// full when the write pointer is one whole lap ahead of the stale read pointer
	assign wr_full  = (wr_bin == {~rd_bin_wr[PTR], rd_bin_wr[PTR-1:0]});
	assign rd_empty = (wr_bin_rd == rd_bin);

	dpram #(
		.PTR       (PTR),
		.payload_t (payload_t)
	) u_dpram (
		.wrclk    (wrclk),
		.wr_en    (wr_push),
		.wr_addr  (wr_bin[PTR-1:0]),
		.wr_data  (wr_data),
		.rdclk    (rdclk),
		.rd_rst_n (rd_rst_n),
		.rd_en    (rd_pop),
		.rd_addr  (rd_bin[PTR-1:0]),
		.rd_data  (rd_data)
	);

endmodule

/* rr_merge.sv */
`timescale 1ns/1ps

module rr_merge import stream_types_pkg::*; (
	input  logic       rdclk,
	input  logic       rd_rst_n,
	input  logic       merge_en,	// level, low pauses new pops

	input  logic       empty0,
	input  logic       empty1,
	output logic       rd_en0,
	output logic       rd_en1,
	input  sample_t    data0,
	input  ctrl_word_t data1,

	output logic       out_valid,
	output bus_word_t  out_word,
	output src_id_t    out_src
);

	src_id_t last_grant;	// source served most recently
	src_id_t src_q;			// source popped in the previous cycle
	logic    pop_q;

	logic req0;
	logic req1;

	assign req0 = merge_en && !empty0;
	assign req1 = merge_en && !empty1;

	// a lone requester always wins, on a tie the other side of last_grant goes
	always_comb begin
		rd_en0 = req0 && (!req1 || last_grant == SRC_CTRL);
		rd_en1 = req1 && (!req0 || last_grant == SRC_SAMPLE);
	end

	always_ff @(posedge rdclk or negedge rd_rst_n) begin
		if (!rd_rst_n) begin
			last_grant <= SRC_CTRL;	// channel 0 first after reset
			src_q      <= SRC_SAMPLE;
			pop_q      <= 1'b0;
		end else begin
			pop_q <= rd_en0 || rd_en1;
			if (rd_en0) begin
				last_grant <= SRC_SAMPLE;
				src_q      <= SRC_SAMPLE;
			end else if (rd_en1) begin
				last_grant <= SRC_CTRL;
				src_q      <= SRC_CTRL;
			end
		end
	end

	// fifo read data lands one cycle after the pop, steer it with the stored source
	always_comb begin
		out_valid = pop_q;
		out_src   = src_q;
		if (src_q == SRC_CTRL) begin
			out_word = bus_word_t'(data1);
		end else begin
			out_word = bus_word_t'(data0);
		end
	end

endmodule

/* merge_top.sv */
`timescale 1ns/1ps

module merge_top import stream_types_pkg::*; #(
	parameter int PTR = 4
) (
	input  logic       wrclk0,
	input  logic       wr_rst_n0,
	input  logic       wr_en0,
	input  sample_t    wr_data0,
	output logic       wr_full0,

	input  logic       wrclk1,
	input  logic       wr_rst_n1,
	input  logic       wr_en1,
	input  ctrl_word_t wr_data1,
	output logic       wr_full1,

	input  logic       rdclk,
	input  logic       rd_rst_n,
	input  logic       merge_en,
	output logic       out_valid,
	output bus_word_t  out_word,
	output src_id_t    out_src
);

	logic       rd_en0;
	logic       rd_en1;
	logic       empty0;
	logic       empty1;
	sample_t    data0;
	ctrl_word_t data1;

	// sensor samples
	async_fifo #(
		.PTR       (PTR),
		.payload_t (sample_t)
	) u_fifo0 (
		.wrclk    (wrclk0),
		.wr_rst_n (wr_rst_n0),
		.wr_en    (wr_en0),
		.wr_data  (wr_data0),
		.wr_full  (wr_full0),
		.rdclk    (rdclk),
		.rd_rst_n (rd_rst_n),
		.rd_en    (rd_en0),
		.rd_data  (data0),
		.rd_empty (empty0)
	);

	// control words
	async_fifo #(
		.PTR       (PTR),
		.payload_t (ctrl_word_t)
	) u_fifo1 (
		.wrclk    (wrclk1),
		.wr_rst_n (wr_rst_n1),
		.wr_en    (wr_en1),
		.wr_data  (wr_data1),
		.wr_full  (wr_full1),
		.rdclk    (rdclk),
		.rd_rst_n (rd_rst_n),
		.rd_en    (rd_en1),
		.rd_data  (data1),
		.rd_empty (empty1)
	);

	rr_merge u_merge (
		.rdclk     (rdclk),
		.rd_rst_n  (rd_rst_n),
		.merge_en  (merge_en),
		.empty0    (empty0),
		.empty1    (empty1),
		.rd_en0    (rd_en0),
		.rd_en1    (rd_en1),
		.data0     (data0),
		.data1     (data1),
		.out_valid (out_valid),
		.out_word  (out_word),
		.out_src   (out_src)
	);

endmodule

/* merge_properties.sv */
`timescale 1ns/1ps

module merge_properties (
	input logic rdclk,
	input logic rd_rst_n,
	input logic empty0,
	input logic empty1,
	input logic rd_en0,
	input logic rd_en1,
	input logic out_valid
);

	// one pop per cycle at most
	a_single_pop: assert property (@(posedge rdclk) disable iff (!rd_rst_n)
		!(rd_en0 && rd_en1))
		else $error("both FIFOs popped in the same cycle");

	a_pop0_not_empty: assert property (@(posedge rdclk) disable iff (!rd_rst_n)
		rd_en0 |-> !empty0)
		else $error("channel 0 popped while empty");

	a_pop1_not_empty: assert property (@(posedge rdclk) disable iff (!rd_rst_n)
		rd_en1 |-> !empty1)
		else $error("channel 1 popped while empty");

	a_valid_after_pop: assert property (@(posedge rdclk) disable iff (!rd_rst_n)
		out_valid == $past(rd_en0 || rd_en1))
		else $error("out_valid does not follow a pop by one cycle");

endmodule

bind rr_merge merge_properties u_props (
	.rdclk     (rdclk),
	.rd_rst_n  (rd_rst_n),
	.empty0    (empty0),
	.empty1    (empty1),
	.rd_en0    (rd_en0),
	.rd_en1    (rd_en1),
	.out_valid (out_valid)
);

/* tb_merge_top.sv */
`timescale 1ns/1ps

module tb_merge_top import stream_types_pkg::*; ();

	localparam int PTR = 4;
	localparam int DEPTH = 1 << PTR;
	localparam int N0 = 40;	// random words on channel 0
	localparam int N1 = 30;
	localparam int PLANNED_WORDS = N0 + N1 + 3 * DEPTH;
	localparam int MODE_ANY = 0;
	localparam int MODE_SAMPLE_ONLY = 1;
	localparam int MODE_ALTERNATE = 2;

	logic       rdclk = 1'b0;
	logic       wrclk0 = 1'b0;
	logic       wrclk1 = 1'b0;
	logic       rd_rst_n;
	logic       wr_rst_n0;
	logic       wr_rst_n1;
	logic       wr_en0;
	logic       wr_en1;
	logic       merge_en;
	sample_t    wr_data0;
	ctrl_word_t wr_data1;
	logic       wr_full0;
	logic       wr_full1;
	logic       out_valid;
	bus_word_t  out_word;
	src_id_t    out_src;

	sample_t     q0 [$];	// accepted writes per source
	ctrl_word_t  q1 [$];
	logic [31:0] rng [2];
	int          n_out = 0;
	int          src_mode = MODE_ANY;
	int          seen_mode = MODE_ANY;
	bit          have_prev = 1'b0;
	src_id_t     prev_src = SRC_SAMPLE;

	always #50 rdclk = ~rdclk;
	always #35 wrclk0 = ~wrclk0;
	always #65 wrclk1 = ~wrclk1;

	merge_top #(.PTR(PTR)) dut (.*);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// oldest pending word of the given source
	function automatic bus_word_t expected_word(input src_id_t src);
		if (src == SRC_CTRL) begin
			return bus_word_t'(q1.pop_front());
		end
		return bus_word_t'(q0.pop_front());
	endfunction

	task automatic stop_run();
		$display("TEST FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_sample(input sample_t got, input sample_t exp, input string what);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
			stop_run();
		end
	endtask

	task automatic check_ctrl(input ctrl_word_t got, input ctrl_word_t exp, input string what);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
			stop_run();
		end
	endtask

	task automatic check_src(input src_id_t got, input src_id_t exp, input string what);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, what, got, exp);
			stop_run();
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
			stop_run();
		end
	endtask

	task automatic wr_edge(input bit ch);
		if (ch) begin
			@(posedge wrclk1);
		end else begin
			@(posedge wrclk0);
		end
		#1;
	endtask

	task automatic drive_word(input bit ch, input logic en, input logic [15:0] d);
		if (ch) begin
			wr_en1   = en;
			wr_data1 = ctrl_word_t'(d);
		end else begin
			wr_en0   = en;
			wr_data0 = sample_t'(d);
		end
	endtask

	// count is of accepted words unless overflow asks for pushes into a full FIFO
	task automatic write_words(input bit ch, input int count, input bit overflow);
		int          done_n;
		logic        full;
		logic [15:0] d;
		done_n = 0;
		while (done_n < count) begin
			wr_edge(ch);
			full = ch ? wr_full1 : wr_full0;	// stable until the next write edge
			rng[ch] = xorshift32(rng[ch]);
			d = rng[ch][31:16];
			if (overflow && !full) begin
				$display("channel %0d had free space during the overflow writes", ch);
				stop_run();
			end
			if (overflow || (!full && rng[ch][1:0] != 2'b00)) begin
				drive_word(ch, 1'b1, d);
				if (!overflow && ch) begin
					q1.push_back(ctrl_word_t'(d));
				end else if (!overflow) begin
					q0.push_back(sample_t'(d));
				end
				done_n++;
			end else begin
				drive_word(ch, 1'b0, d);
			end
		end
		wr_edge(ch);
		drive_word(ch, 1'b0, 16'h0);
	endtask

	task automatic wait_drained();
		while (q0.size() != 0 || q1.size() != 0) begin
			@(posedge rdclk);
		end
		repeat (4) @(posedge rdclk);
	endtask

	task automatic release_and_drain(input int mode, input int expect_n, input string what);
		int base;
		@(posedge rdclk);
		#1;
		base = n_out;
		src_mode = mode;
		merge_en = 1'b1;
		wait_drained();
		if (n_out - base != expect_n) begin
			$display("%s gave %0d words instead of %0d", what, n_out - base, expect_n);
			stop_run();
		end
		src_mode = MODE_ANY;
	endtask

	always @(negedge rdclk) begin : compare_outputs
		bus_word_t exp_word;
		if (src_mode != seen_mode) begin
			have_prev = 1'b0;	// new burst
			seen_mode = src_mode;
		end
		if (rd_rst_n === 1'b1 && out_valid === 1'b1) begin
			if (src_mode == MODE_SAMPLE_ONLY) begin
				check_src(out_src, SRC_SAMPLE, "source during channel 0 drain");
			end else if (src_mode == MODE_ALTERNATE && have_prev) begin
				check_src(out_src, src_id_t'(~prev_src), "round-robin alternation");
			end
			if ((out_src == SRC_CTRL) ? (q1.size() == 0) : (q0.size() == 0)) begin
				$display("word %h from source %0d came out with nothing pending", out_word, out_src);
				stop_run();
			end
			exp_word = expected_word(out_src);
			if (out_src == SRC_CTRL) begin
				check_ctrl(ctrl_word_t'(out_word), ctrl_word_t'(exp_word), "control word");
			end else begin
				check_sample(sample_t'(out_word), sample_t'(exp_word), "sensor sample");
			end
			prev_src = out_src;
			have_prev = 1'b1;
			n_out++;
		end
	end

	initial begin : watchdog
		repeat (PLANNED_WORDS * 20 + 200) @(posedge rdclk);
		$display("timeout: the output did not drain in time");
		stop_run();
	end

	initial begin : main_sequence
		int base;
		wr_en0 = 1'b0;
		wr_en1 = 1'b0;
		wr_data0 = '0;
		wr_data1 = '0;
		merge_en = 1'b1;
		rd_rst_n = 1'b0;
		wr_rst_n0 = 1'b0;
		wr_rst_n1 = 1'b0;
		rng[0] = 32'h3a7d;
		rng[1] = xorshift32(32'h3a7d);	// second stream from the same seed
		repeat (5) @(posedge rdclk);
		#1;
		rd_rst_n = 1'b1;
		wr_rst_n0 = 1'b1;
		wr_rst_n1 = 1'b1;

		repeat (20) @(posedge rdclk);	// idle bus after reset
		check_flag(wr_full0, 1'b0, "wr_full0 after reset");
		check_flag(wr_full1, 1'b0, "wr_full1 after reset");
		if (n_out != 0) begin
			$display("the bus carried %0d words with no writes", n_out);
			stop_run();
		end

		fork
			write_words(1'b0, N0, 1'b0);
			write_words(1'b1, N1, 1'b0);
		join
		wait_drained();
		if (n_out != N0 + N1) begin
			$display("random traffic gave %0d words instead of %0d", n_out, N0 + N1);
			stop_run();
		end

		@(posedge rdclk);
		#1;
		merge_en = 1'b0;
		base = n_out;
		write_words(1'b0, DEPTH, 1'b0);
		check_flag(wr_full0, 1'b1, "wr_full0 after filling channel 0");
		write_words(1'b0, 5, 1'b1);	// dropped writes
		repeat (8) @(posedge rdclk);
		if (n_out != base) begin
			$display("words came out while the merge was paused");
			stop_run();
		end
		release_and_drain(MODE_SAMPLE_ONLY, DEPTH, "channel 0 backlog");

		@(posedge rdclk);
		#1;
		merge_en = 1'b0;
		base = n_out;
		fork
			write_words(1'b0, DEPTH, 1'b0);
			write_words(1'b1, DEPTH, 1'b0);
		join
		check_flag(wr_full0, 1'b1, "wr_full0 with both backlogged");
		check_flag(wr_full1, 1'b1, "wr_full1 with both backlogged");
		write_words(1'b1, 4, 1'b1);
		repeat (8) @(posedge rdclk);
		if (n_out != base) begin
			$display("words came out while the merge was paused");
			stop_run();
		end
		release_and_drain(MODE_ALTERNATE, 2 * DEPTH, "dual backlog");

		$display("TEST OK");
		$finish;
	end

endmodule

/* list.f */
stream_types_pkg.sv
gray_pkg.sv
dpram.sv
ptr_sync.sv
async_fifo.sv
rr_merge.sv
merge_top.sv
merge_properties.sv
tb_merge_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_merge_top
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the run prints the pass line
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx 'TEST OK'

clean:
	rm -rf $(OBJ_DIR)
